//--- memTagGolden.dat
# stall clear toRec flushAll head tail | ld: v rv addr map size ptr hasMshr mshrId | fwd fwdMiss alloc allocId addrHit hitId mshrRd dcHit
# st: v rv addr map size ptr data(x=random) conflict | exp ld: ex oV oRV state hasM mId rec recHit | exp st: ex oV state ordViol rec
0 0 0 0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 x 0  0 0 0 0 0 0 0 0  0 0 0 0 0
0 0 0 0 0 0  1 1 100 0 2 1 0 0  1 0 0 0 0 0 0 0  0 0 0 0 0 0 x 0  1 1 1 1 0 0 0 0  0 0 0 0 0
0 0 0 0 0 0  1 1 104 0 2 1 0 0  1 1 0 0 0 0 0 0  0 0 0 0 0 0 x 0  1 1 0 0 0 0 1 0  0 0 0 0 0
0 0 0 0 0 0  1 1 108 0 2 1 1 2  0 0 1 3 1 1 0 0  0 0 0 0 0 0 x 0  1 1 0 0 1 2 1 1  0 0 0 0 0
0 0 0 0 0 0  1 1 10c 0 2 1 0 0  0 0 1 3 0 0 1 0  0 0 0 0 0 0 x 0  1 1 1 1 1 3 0 0  0 0 0 0 0
0 0 0 0 0 0  1 1 110 0 2 1 0 0  0 0 0 0 1 2 1 0  0 0 0 0 0 0 x 0  1 1 1 1 0 2 0 1  0 0 0 0 0
0 0 0 0 0 0  1 1 114 0 2 1 0 0  0 0 0 0 0 0 0 1  1 1 200 0 2 5 11223344 0  1 1 1 1 0 0 0 0  1 1 1 0 0
0 0 0 0 0 0  1 1 118 0 2 1 0 0  0 0 0 0 0 0 0 0  1 1 204 0 2 6 55667788 1  1 1 0 0 0 0 1 0  1 1 2 1 0
0 0 0 0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0  1 0 208 0 2 7 0badf00d 0  0 0 0 0 0 0 0 0  1 1 0 0 1
0 0 0 0 0 0  1 1 120 2 2 1 0 0  0 0 0 0 0 0 0 1  1 1 20c 2 2 8 12345678 1  1 1 1 3 0 0 0 0  1 1 5 1 0
0 0 0 0 0 0  1 1 125 0 1 1 0 0  0 0 0 0 0 0 0 1  1 1 212 0 2 9 87654321 1  1 1 1 4 0 0 0 0  1 1 6 1 0
0 0 0 0 0 0  1 1 12a 0 2 1 0 0  0 0 0 0 0 0 0 1  1 1 213 0 0 a 000000ff 0  1 1 1 4 0 0 0 0  1 1 1 0 0
0 0 1 0 e 2  1 1 130 0 2 f 0 0  0 0 0 0 0 0 0 1  1 1 220 0 2 3 cafe0001 0  0 0 1 0 0 0 0 0  1 1 1 0 0
0 0 1 0 e 2  1 1 134 0 2 2 0 0  0 0 0 0 0 0 0 1  1 1 224 0 2 0 cafe0002 1  1 1 1 1 0 0 0 0  0 0 0 0 0
0 0 0 1 0 0  1 1 138 0 2 5 0 0  0 0 0 0 0 0 0 0  1 0 228 0 2 6 cafe0003 0  0 0 0 0 0 0 0 0  0 0 0 0 0
0 0 0 0 0 0  1 1 140 0 2 1 0 0  0 0 0 0 0 0 0 1  1 1 230 0 2 4 99aabbcc 0  1 1 1 1 0 0 0 0  1 1 1 0 0
1 0 0 0 0 0  1 1 150 0 1 1 0 0  0 0 0 0 0 0 0 1  1 1 240 2 2 4 aaaa0000 1  0 0 1 0 0 0 0 0  0 0 0 0 0
1 0 0 0 0 0  1 1 150 0 1 1 0 0  0 0 0 0 0 0 0 0  1 1 240 2 2 4 aaaa0000 1  0 0 0 0 0 0 0 0  0 0 0 0 0
0 0 0 0 0 0  1 1 144 0 2 1 0 0  0 0 0 0 0 0 0 1  1 1 234 0 2 4 x 0  1 1 1 1 0 0 0 0  1 1 1 0 0
0 1 0 0 0 0  1 1 148 0 2 1 0 0  0 0 0 0 0 0 0 1  1 1 238 0 2 4 x 0  0 0 1 0 0 0 0 0  0 0 0 0 0
0 0 0 0 0 0  1 1 14d 0 0 1 0 0  0 0 0 0 0 0 0 1  0 0 0 0 0 0 x 0  1 1 1 1 0 0 0 0  0 0 0 0 0
0 0 0 0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0  0 0 0 0 0 0 x 0  0 0 0 0 0 0 0 0  0 0 0 0 0

//--- filelist.f
+incdir+.
memOpPkg.sv
pipeCtrlPkg.sv
flushRangeCheck.sv
loadTagResolve.sv
storeTagResolve.sv
memTagAccessStage.sv
tbMemTagChecker.sv
tbMemTagAccess.sv

//--- tbMemTagAccess.sv
/*
 * Testbench top for the memory tag-access stage
 * Clock, reset, golden vector reader, falling-edge stimulus and watchdog
 */
`timescale 1ns/1ps

module tbMemTagAccess;
    import memOpPkg::*;
    import pipeCtrlPkg::*;

    localparam int ClkPeriod = 40;
    localparam int FieldCount = 43;

    logic clk;
    logic rstN;
    logic stall;
    logic clear;
    logic toRecoveryPhase;
    logic flushAll;
    activeListPtrT flushHead;
    activeListPtrT flushTail;
    logic ldInValid;
    logic ldInRegValid;
    addrT ldInAddr;
    memMapT ldInMapType;
    accessSizeT ldInSize;
    activeListPtrT ldInAlPtr;
    logic ldInHasMshr;
    mshrIdT ldInMshrId;
    logic ldForwarded;
    logic ldForwardMiss;
    logic ldMshrAllocated;
    mshrIdT ldAllocMshrId;
    logic ldMshrAddrHit;
    mshrIdT ldAddrHitMshrId;
    logic ldMshrReadHit;
    logic ldDcReadHit;
    logic stInValid;
    logic stInRegValid;
    addrT stInAddr;
    memMapT stInMapType;
    accessSizeT stInSize;
    activeListPtrT stInAlPtr;
    dataT stInData;
    logic stConflict;

    logic executeLoad;
    addrT executedLoadAddr;
    logic ldOutValid;
    logic ldOutRegValid;
    execStateT ldOutExecState;
    logic ldOutHasMshr;
    mshrIdT ldOutMshrId;
    logic ldRecordEntry;
    logic ldRecordAddrHit;
    indexSubsetT ldRecordAddrSubset;
    logic executeStore;
    addrT executedStoreAddr;
    dataT executedStoreData;
    logic stOutValid;
    execStateT stOutExecState;
    logic orderViolation;
    logic stRecordEntry;
    indexSubsetT stRecordAddrSubset;

    // Expected values for the op captured at the coming rising edge
    logic expExecuteLoad;
    logic expLdOutValid;
    logic expLdOutRegValid;
    logic [2:0] expLdExecState;
    logic expLdHasMshr;
    logic [1:0] expLdMshrId;
    logic expLdRecordEntry;
    logic expLdRecordAddrHit;
    logic expExecuteStore;
    logic expStOutValid;
    logic [2:0] expStExecState;
    logic expOrderViolation;
    logic expStRecordEntry;
    addrT expLdAddr;
    addrT expStAddr;
    dataT expStData;

    // Model of the pipeline register contents
    addrT heldLdAddr;
    addrT heldStAddr;
    dataT heldStData;

    logic checkEn;
    logic loadDone;
    int errorCount;
    int fileErrors;
    string vectors[$];

    memTagAccessStage DUT (.*);

    tbMemTagChecker outputCheck (.*);

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    task automatic splitFields(input string line, output logic [31:0] vals[$]);
        string tok;
        logic [31:0] v;
        int ch;
        vals.delete();
        tok = "";
        for (int i = 0; i <= line.len(); i++) begin
            ch = (i < line.len()) ? line.getc(i) : 32;
            if (ch == 32 || ch == 9 || ch == 10 || ch == 13) begin
                if (tok.len() > 0) begin
                    void'($sscanf(tok, "%h", v));
                    vals.push_back(v);
                    tok = "";
                end
            end else begin
                tok = {tok, line.substr(i, i)};
            end
        end
    endtask

    task automatic applyVector(input logic [31:0] f[$]);
        dataT stData;
        // An x in the data column asks for a random fill
        stData = $isunknown(f[28]) ? dataT'($urandom) : f[28];
        stall <= f[0][0];
        clear <= f[1][0];
        toRecoveryPhase <= f[2][0];
        flushAll <= f[3][0];
        flushHead <= f[4][3:0];
        flushTail <= f[5][3:0];
        ldInValid <= f[6][0];
        ldInRegValid <= f[7][0];
        ldInAddr <= f[8];
        ldInMapType <= memMapT'(f[9][1:0]);
        ldInSize <= accessSizeT'(f[10][1:0]);
        ldInAlPtr <= f[11][3:0];
        ldInHasMshr <= f[12][0];
        ldInMshrId <= f[13][1:0];
        ldForwarded <= f[14][0];
        ldForwardMiss <= f[15][0];
        ldMshrAllocated <= f[16][0];
        ldAllocMshrId <= f[17][1:0];
        ldMshrAddrHit <= f[18][0];
        ldAddrHitMshrId <= f[19][1:0];
        ldMshrReadHit <= f[20][0];
        ldDcReadHit <= f[21][0];
        stInValid <= f[22][0];
        stInRegValid <= f[23][0];
        stInAddr <= f[24];
        stInMapType <= memMapT'(f[25][1:0]);
        stInSize <= accessSizeT'(f[26][1:0]);
        stInAlPtr <= f[27][3:0];
        stInData <= stData;
        stConflict <= f[29][0];
        expExecuteLoad <= f[30][0];
        expLdOutValid <= f[31][0];
        expLdOutRegValid <= f[32][0];
        expLdExecState <= f[33][2:0];
        expLdHasMshr <= f[34][0];
        expLdMshrId <= f[35][1:0];
        expLdRecordEntry <= f[36][0];
        expLdRecordAddrHit <= f[37][0];
        expExecuteStore <= f[38][0];
        expStOutValid <= f[39][0];
        expStExecState <= f[40][2:0];
        expOrderViolation <= f[41][0];
        expStRecordEntry <= f[42][0];
        // Stall keeps the registered address and data
        if (!f[0][0]) begin
            heldLdAddr = f[8];
            heldStAddr = f[24];
            heldStData = stData;
        end
        expLdAddr <= heldLdAddr;
        expStAddr <= heldStAddr;
        expStData <= heldStData;
    endtask

    initial begin
        int fd;
        string line;
        logic [31:0] vals[$];
        void'($urandom(32'h19a31d6d));
        rstN = 1'b0;
        {stall, clear, toRecoveryPhase, flushAll, flushHead, flushTail} = '0;
        {ldInValid, ldInRegValid, ldInAddr, ldInAlPtr, ldInHasMshr, ldInMshrId} = '0;
        ldInMapType = mapMemory;
        ldInSize = accessByte;
        {ldForwarded, ldForwardMiss, ldMshrAllocated, ldAllocMshrId} = '0;
        {ldMshrAddrHit, ldAddrHitMshrId, ldMshrReadHit, ldDcReadHit} = '0;
        {stInValid, stInRegValid, stInAddr, stInAlPtr, stInData, stConflict} = '0;
        stInMapType = mapMemory;
        stInSize = accessByte;
        // Idle outputs expected while in reset
        {expExecuteLoad, expLdOutValid, expLdOutRegValid, expLdExecState} = '0;
        {expLdHasMshr, expLdMshrId, expLdRecordEntry, expLdRecordAddrHit} = '0;
        {expExecuteStore, expStOutValid, expStExecState} = '0;
        {expOrderViolation, expStRecordEntry} = '0;
        {expLdAddr, expStAddr, expStData} = '0;
        {heldLdAddr, heldStAddr, heldStData} = '0;
        checkEn = 1'b0;
        loadDone = 1'b0;
        fileErrors = 0;

        fd = $fopen("memTagGolden.dat", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file memTagGolden.dat");
            fileErrors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) && line.len() > 0 && line.getc(0) != "#") begin
                    splitFields(line, vals);
                    if (vals.size() == FieldCount) begin
                        vectors.push_back(line);
                    end else if (vals.size() != 0) begin
                        $display("Golden line has %0d fields instead of %0d: %s",
                                 vals.size(), FieldCount, line);
                        fileErrors++;
                    end
                end
            end
            $fclose(fd);
            if (vectors.size() == 0) begin
                $display("The golden file holds no test vectors");
                fileErrors++;
            end
        end
        loadDone = 1'b1;

        repeat (9) @(posedge clk);
        @(negedge clk);
        // Reset state is checked at the release edge
        checkEn <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        rstN <= 1'b1;
        foreach (vectors[i]) begin
            @(negedge clk);
            splitFields(vectors[i], vals);
            applyVector(vals);
            checkEn <= 1'b1;
        end
        // Last vector is checked at this edge
        @(negedge clk);
        checkEn <= 1'b0;
        @(negedge clk);
        $display("Run complete: %0d mismatches, %0d other errors", errorCount, fileErrors);
        if (errorCount + fileErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        wait (loadDone);
        #((vectors.size() + 20) * ClkPeriod);
        $display("Timeout: the run did not complete within the expected time");
        $display("Errors found");
        $finish;
    end

endmodule

//--- tbMemTagChecker.sv
/*
 * Testbench checker for the memory tag-access stage
 * Compares DUT outputs with the golden expectations on the falling edge
 */
`timescale 1ns/1ps

module tbMemTagChecker (
    input logic clk,
    input logic checkEn,
    input logic expExecuteLoad,
    input logic expLdOutValid,
    input logic expLdOutRegValid,
    input logic [2:0] expLdExecState,
    input logic expLdHasMshr,
    input logic [1:0] expLdMshrId,
    input logic expLdRecordEntry,
    input logic expLdRecordAddrHit,
    input logic expExecuteStore,
    input logic expStOutValid,
    input logic [2:0] expStExecState,
    input logic expOrderViolation,
    input logic expStRecordEntry,
    input memOpPkg::addrT expLdAddr,
    input memOpPkg::addrT expStAddr,
    input memOpPkg::dataT expStData,
    input logic executeLoad,
    input memOpPkg::addrT executedLoadAddr,
    input logic ldOutValid,
    input logic ldOutRegValid,
    input pipeCtrlPkg::execStateT ldOutExecState,
    input logic ldOutHasMshr,
    input memOpPkg::mshrIdT ldOutMshrId,
    input logic ldRecordEntry,
    input logic ldRecordAddrHit,
    input memOpPkg::indexSubsetT ldRecordAddrSubset,
    input logic executeStore,
    input memOpPkg::addrT executedStoreAddr,
    input memOpPkg::dataT executedStoreData,
    input logic stOutValid,
    input pipeCtrlPkg::execStateT stOutExecState,
    input logic orderViolation,
    input logic stRecordEntry,
    input memOpPkg::indexSubsetT stRecordAddrSubset,
    output int errorCount
);
    initial errorCount = 0;

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s expected %h actual %h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    // Outputs settle after the rising edge, so the falling edge sees stable values
    always @(negedge clk) begin
        if (checkEn) begin
            compareValue("executeLoad", expExecuteLoad, executeLoad);
            compareValue("executedLoadAddr", expLdAddr, executedLoadAddr);
            compareValue("ldOutValid", expLdOutValid, ldOutValid);
            compareValue("ldOutRegValid", expLdOutRegValid, ldOutRegValid);
            compareValue("ldOutExecState", expLdExecState, ldOutExecState);
            compareValue("ldOutHasMshr", expLdHasMshr, ldOutHasMshr);
            compareValue("ldOutMshrId", expLdMshrId, ldOutMshrId);
            compareValue("ldRecordEntry", expLdRecordEntry, ldRecordEntry);
            compareValue("ldRecordAddrHit", expLdRecordAddrHit, ldRecordAddrHit);
            // Replay subset is address bits 6 to 4
            compareValue("ldRecordAddrSubset", expLdAddr[6:4], ldRecordAddrSubset);
            compareValue("executeStore", expExecuteStore, executeStore);
            compareValue("executedStoreAddr", expStAddr, executedStoreAddr);
            compareValue("executedStoreData", expStData, executedStoreData);
            compareValue("stOutValid", expStOutValid, stOutValid);
            compareValue("stOutExecState", expStExecState, stOutExecState);
            compareValue("orderViolation", expOrderViolation, orderViolation);
            compareValue("stRecordEntry", expStRecordEntry, stRecordEntry);
            compareValue("stRecordAddrSubset", expStAddr[6:4], stRecordAddrSubset);
        end
    end

endmodule

//--- memTagAccessStage.sv
/*
 * Memory tag-access stage top level
 * Load and store pipeline registers, flush checks and both lane resolvers
 */
`timescale 1ns/1ps

module memTagAccessStage (
    input logic clk,
    input logic rstN,
    input logic stall,
    input logic clear,
    input logic toRecoveryPhase,
    input logic flushAll,
    input pipeCtrlPkg::activeListPtrT flushHead,
    input pipeCtrlPkg::activeListPtrT flushTail,
    input logic ldInValid,
    input logic ldInRegValid,
    input memOpPkg::addrT ldInAddr,
    input memOpPkg::memMapT ldInMapType,
    input memOpPkg::accessSizeT ldInSize,
    input pipeCtrlPkg::activeListPtrT ldInAlPtr,
    input logic ldInHasMshr,
    input memOpPkg::mshrIdT ldInMshrId,
    input logic ldForwarded,
    input logic ldForwardMiss,
    input logic ldMshrAllocated,
    input memOpPkg::mshrIdT ldAllocMshrId,
    input logic ldMshrAddrHit,
    input memOpPkg::mshrIdT ldAddrHitMshrId,
    input logic ldMshrReadHit,
    input logic ldDcReadHit,
    input logic stInValid,
    input logic stInRegValid,
    input memOpPkg::addrT stInAddr,
    input memOpPkg::memMapT stInMapType,
    input memOpPkg::accessSizeT stInSize,
    input pipeCtrlPkg::activeListPtrT stInAlPtr,
    input memOpPkg::dataT stInData,
    input logic stConflict,
    output logic executeLoad,
    output memOpPkg::addrT executedLoadAddr,
    output logic ldOutValid,
    output logic ldOutRegValid,
    output pipeCtrlPkg::execStateT ldOutExecState,
    output logic ldOutHasMshr,
    output memOpPkg::mshrIdT ldOutMshrId,
    output logic ldRecordEntry,
    output logic ldRecordAddrHit,
    output memOpPkg::indexSubsetT ldRecordAddrSubset,
    output logic executeStore,
    output memOpPkg::addrT executedStoreAddr,
    output memOpPkg::dataT executedStoreData,
    output logic stOutValid,
    output pipeCtrlPkg::execStateT stOutExecState,
    output logic orderViolation,
    output logic stRecordEntry,
    output memOpPkg::indexSubsetT stRecordAddrSubset
);
    import memOpPkg::*;
    import pipeCtrlPkg::*;

    // Load lane register
    logic ldValidReg;
    logic ldRegValidReg;
    addrT ldAddrReg;
    memMapT ldMapTypeReg;
    accessSizeT ldSizeReg;
    activeListPtrT ldAlPtrReg;
    logic ldHasMshrReg;
    mshrIdT ldMshrIdReg;

    // Store lane register
    logic stValidReg;
    logic stRegValidReg;
    addrT stAddrReg;
    memMapT stMapTypeReg;
    accessSizeT stSizeReg;
    activeListPtrT stAlPtrReg;
    dataT stDataReg;

    logic ldFlushed;
    logic stFlushed;

    // Valids hold under stall, clear still lets the next op in
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ldValidReg <= 1'b0;
            ldRegValidReg <= 1'b0;
            stValidReg <= 1'b0;
            stRegValidReg <= 1'b0;
        end else if (!stall) begin
            ldValidReg <= ldInValid;
            ldRegValidReg <= ldInRegValid;
            stValidReg <= stInValid;
            stRegValidReg <= stInRegValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ldAddrReg <= ldInAddr;
            ldMapTypeReg <= ldInMapType;
            ldSizeReg <= ldInSize;
            ldAlPtrReg <= ldInAlPtr;
            ldHasMshrReg <= ldInHasMshr;
            ldMshrIdReg <= ldInMshrId;
            stAddrReg <= stInAddr;
            stMapTypeReg <= stInMapType;
            stSizeReg <= stInSize;
            stAlPtrReg <= stInAlPtr;
            stDataReg <= stInData;
        end
    end

    flushRangeCheck ldFlushCheck (
        .toRecoveryPhase(toRecoveryPhase),
        .flushAll(flushAll),
        .flushHead(flushHead),
        .flushTail(flushTail),
        .opPtr(ldAlPtrReg),
        .flushed(ldFlushed)
    );

    flushRangeCheck stFlushCheck (
        .toRecoveryPhase(toRecoveryPhase),
        .flushAll(flushAll),
        .flushHead(flushHead),
        .flushTail(flushTail),
        .opPtr(stAlPtrReg),
        .flushed(stFlushed)
    );

    assign executedLoadAddr = ldAddrReg;

    loadTagResolve loadLane (
        .regValidIn(ldRegValidReg),
        .valid(ldValidReg),
        .stall(stall),
        .clear(clear),
        .flushed(ldFlushed),
        .addr(ldAddrReg),
        .mapType(ldMapTypeReg),
        .size(ldSizeReg),
        .hasMshrIn(ldHasMshrReg),
        .mshrIdIn(ldMshrIdReg),
        .ldForwarded(ldForwarded),
        .ldForwardMiss(ldForwardMiss),
        .ldMshrAllocated(ldMshrAllocated),
        .ldAllocMshrId(ldAllocMshrId),
        .ldMshrAddrHit(ldMshrAddrHit),
        .ldAddrHitMshrId(ldAddrHitMshrId),
        .ldMshrReadHit(ldMshrReadHit),
        .ldDcReadHit(ldDcReadHit),
        .executeLoad(executeLoad),
        .outValid(ldOutValid),
        .outRegValid(ldOutRegValid),
        .execState(ldOutExecState),
        .hasMshr(ldOutHasMshr),
        .mshrId(ldOutMshrId),
        .recordEntry(ldRecordEntry),
        .recordAddrHit(ldRecordAddrHit),
        .recordSubset(ldRecordAddrSubset)
    );

    storeTagResolve storeLane (
        .regValidIn(stRegValidReg),
        .valid(stValidReg),
        .stall(stall),
        .clear(clear),
        .flushed(stFlushed),
        .addr(stAddrReg),
        .mapType(stMapTypeReg),
        .size(stSizeReg),
        .data(stDataReg),
        .conflict(stConflict),
        .executeStore(executeStore),
        .storeAddr(executedStoreAddr),
        .storeData(executedStoreData),
        .outValid(stOutValid),
        .execState(stOutExecState),
        .orderViolation(orderViolation),
        .recordEntry(stRecordEntry),
        .recordSubset(stRecordAddrSubset)
    );

endmodule

//--- storeTagResolve.sv
/*
 * Store lane of the tag-access stage
 * Store-queue strobe, order violation, replay record, fault check
 */
`timescale 1ns/1ps
`include "memTagMacros.svh"

module storeTagResolve (
    input logic regValidIn,
    input logic valid,
    input logic stall,
    input logic clear,
    input logic flushed,
    input memOpPkg::addrT addr,
    input memOpPkg::memMapT mapType,
    input memOpPkg::accessSizeT size,
    input memOpPkg::dataT data,
    input logic conflict,
    output logic executeStore,
    output memOpPkg::addrT storeAddr,
    output memOpPkg::dataT storeData,
    output logic outValid,
    output pipeCtrlPkg::execStateT execState,
    output logic orderViolation,
    output logic recordEntry,
    output memOpPkg::indexSubsetT recordSubset
);
    import memOpPkg::*;
    import pipeCtrlPkg::*;

    logic update;
    logic finished;

    assign update = valid & ~stall & ~clear & ~flushed;
    assign finished = update & regValidIn;

    // A younger load already read stale data
    assign orderViolation = finished & conflict;

    always_comb begin
        if (!finished) begin
            execState = notFinished;
        end else if (mapType == mapIllegal) begin
            execState = faultStoreViolation;
        end else if (isMisaligned(addr, size)) begin
            execState = faultStoreMisaligned;
        end else if (conflict) begin
            execState = refetchNext;
        end else begin
            execState = success;
        end
    end

    assign executeStore = update;
    assign storeAddr = addr;
    assign storeData = data;
    assign outValid = update;

    // Store with invalid source operands is replayed
    assign recordEntry = update & ~regValidIn;
    assign recordSubset = addr[`MT_LINE_OFFSET_BITS +: `MT_INDEX_SUBSET_BITS];

endmodule

//--- loadTagResolve.sv
/*
 * Load lane of the tag-access stage
 * Data-source resolution, MSHR id selection, replay record, fault check
 */
`timescale 1ns/1ps
`include "memTagMacros.svh"

module loadTagResolve (
    input logic regValidIn,
    input logic valid,
    input logic stall,
    input logic clear,
    input logic flushed,
    input memOpPkg::addrT addr,
    input memOpPkg::memMapT mapType,
    input memOpPkg::accessSizeT size,
    input logic hasMshrIn,
    input memOpPkg::mshrIdT mshrIdIn,
    input logic ldForwarded,
    input logic ldForwardMiss,
    input logic ldMshrAllocated,
    input memOpPkg::mshrIdT ldAllocMshrId,
    input logic ldMshrAddrHit,
    input memOpPkg::mshrIdT ldAddrHitMshrId,
    input logic ldMshrReadHit,
    input logic ldDcReadHit,
    output logic executeLoad,
    output logic outValid,
    output logic outRegValid,
    output pipeCtrlPkg::execStateT execState,
    output logic hasMshr,
    output memOpPkg::mshrIdT mshrId,
    output logic recordEntry,
    output logic recordAddrHit,
    output memOpPkg::indexSubsetT recordSubset
);
    import memOpPkg::*;
    import pipeCtrlPkg::*;

    logic update;
    logic resolvedRegValid;

    assign update = valid & ~stall & ~clear & ~flushed;

    // Ownership is kept once taken, or gained by a fresh allocation
    assign hasMshr = hasMshrIn | ldMshrAllocated;

    always_comb begin
        if (hasMshrIn) begin
            mshrId = mshrIdIn;
        end else if (ldMshrAllocated) begin
            mshrId = ldAllocMshrId;
        end else if (ldMshrAddrHit) begin
            mshrId = ldAddrHitMshrId;
        end else begin
            mshrId = mshrIdIn;
        end
    end

    // Data source priority: forwarding, owned MSHR, MSHR hit, cache hit
    always_comb begin
        if (ldForwarded) begin
            resolvedRegValid = regValidIn & ~ldForwardMiss;
        end else if (hasMshr) begin
            resolvedRegValid = regValidIn & ldMshrReadHit;
        end else if (ldMshrReadHit) begin
            resolvedRegValid = regValidIn;
        end else begin
            resolvedRegValid = regValidIn & ldDcReadHit;
        end
    end

    always_comb begin
        if (!(update && resolvedRegValid)) begin
            execState = notFinished;
        end else if (mapType == mapIllegal) begin
            execState = faultLoadViolation;
        end else if (isMisaligned(addr, size)) begin
            execState = faultLoadMisaligned;
        end else begin
            execState = success;
        end
    end

    assign executeLoad = update;
    assign outValid = update;
    assign outRegValid = resolvedRegValid;

    // Loads without data go to the replay queue
    assign recordEntry = update & ~resolvedRegValid;
    assign recordAddrHit = ldMshrAddrHit;
    assign recordSubset = addr[`MT_LINE_OFFSET_BITS +: `MT_INDEX_SUBSET_BITS];

endmodule

//--- flushRangeCheck.sv
/*
 * Selective flush detector
 * Tests an active-list pointer against the circular flush range
 */
`timescale 1ns/1ps

module flushRangeCheck (
    input logic toRecoveryPhase,
    input logic flushAll,
    input pipeCtrlPkg::activeListPtrT flushHead,
    input pipeCtrlPkg::activeListPtrT flushTail,
    input pipeCtrlPkg::activeListPtrT opPtr,
    output logic flushed
);
    import pipeCtrlPkg::*;

    // Distances from the range head, wrapping with the list depth
    activeListPtrT opOffset;
    activeListPtrT rangeSize;
    logic inRange;

    assign opOffset = opPtr - flushHead;
    assign rangeSize = flushTail - flushHead;

    // Head equal to tail gives a zero size, so nothing matches
    assign inRange = opOffset < rangeSize;

    assign flushed = flushAll | (toRecoveryPhase & inRange);

endmodule

//--- pipeCtrlPkg.sv
/*
 * Pipeline and recovery types
 * Active-list pointer and the execution state reported per op
 */
`include "memTagMacros.svh"

package pipeCtrlPkg;

    typedef logic [$clog2(`MT_ACTIVE_LIST_DEPTH)-1:0] activeListPtrT;

    // Result of an op leaving the tag-access stage
    typedef enum logic [2:0] {
        notFinished = 3'd0,
        success = 3'd1,
        refetchNext = 3'd2,
        faultLoadViolation = 3'd3,
        faultLoadMisaligned = 3'd4,
        faultStoreViolation = 3'd5,
        faultStoreMisaligned = 3'd6
    } execStateT;

endpackage

//--- memOpPkg.sv
/*
 * Memory access types: address, store data, index subset, MSHR id,
 * access size and memory map region, plus the misalignment check
 */
`include "memTagMacros.svh"

package memOpPkg;

    typedef logic [`MT_ADDR_WIDTH-1:0] addrT;
    typedef logic [`MT_DATA_WIDTH-1:0] dataT;
    typedef logic [`MT_INDEX_SUBSET_BITS-1:0] indexSubsetT;
    typedef logic [$clog2(`MT_MSHR_NUM)-1:0] mshrIdT;

    typedef enum logic [1:0] {
        accessByte = 2'd0,
        accessHalf = 2'd1,
        accessWord = 2'd2
    } accessSizeT;

    typedef enum logic [1:0] {
        mapMemory = 2'd0,
        mapIo = 2'd1,
        mapIllegal = 2'd2
    } memMapT;

    // Half needs bit 0 clear, word needs both low bits clear
    function automatic logic isMisaligned(input addrT addr, input accessSizeT size);
        logic misaligned;
        case (size)
            accessHalf: misaligned = addr[0];
            accessWord: misaligned = addr[1] | addr[0];
            default: misaligned = 1'b0;
        endcase
        return misaligned;
    endfunction

endpackage

//--- memTagMacros.svh
/*
 * Width and depth macros for the memory tag-access stage
 * Address and data widths, cache line layout, MSHR and active-list sizes
 */
`ifndef MEM_TAG_MACROS_SVH
`define MEM_TAG_MACROS_SVH

// Address and store data
`define MT_ADDR_WIDTH 32
`define MT_DATA_WIDTH 32

// Data cache line layout
`define MT_LINE_OFFSET_BITS 4
`define MT_INDEX_SUBSET_BITS 3

// Miss handling
`define MT_MSHR_NUM 4

// Recovery
`define MT_ACTIVE_LIST_DEPTH 16

`endif
